//--- src.f
hdl/video_pkg.sv
hdl/pixel_ingress.sv
hdl/rgb_resampler.sv
hdl/luma_calc.sv
hdl/pixel_merge.sv
hdl/video_resample_top.sv
bench/video_resample_tb.sv

//--- bench/video_resample_tb.sv
// Video resample testbench
module video_resample_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import video_pkg::*;

  // Roughly twice the summed length of all tests
  localparam int cycle_limit = 4000;
  // Accept edge to output transfer edge with out_ready high
  localparam int pipe_latency = 3;

  typedef struct packed {
    pixel_out_t  beat;
    logic [31:0] cycle;
  } expect_t;

  logic       clk;
  logic       reset;
  pixel_in_t  in_pixel;
  logic       in_valid;
  logic       in_ready;
  pixel_out_t out_pixel;
  logic       out_valid;
  logic       out_ready;

  integer     seed;
  int         errors = 0;
  int         cycle = 0;
  int         accepted = 0;
  int         received = 0;
  int         last_latency = 0;
  logic       stall_enable;
  logic       stall_draw = 1'b1;
  string      test_name = "none";
  expect_t    expect_q[$];
  int         out_cycles[$];
  logic       hold_pending = 1'b0;
  pixel_out_t held_beat;

  video_resample_top #(
    .r_weight (default_r_weight),
    .g_weight (default_g_weight),
    .b_weight (default_b_weight)
  ) video_resample_top_i (
    .clk       (clk),
    .reset     (reset),
    .in_pixel  (in_pixel),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_pixel (out_pixel),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("errors: %0d, beats accepted: %0d, beats received: %0d",
               errors, accepted, received);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Stall draws happen away from the rising edge where stimulus is drawn
  always @(negedge clk) begin
    if (stall_enable) begin
      stall_draw = ($random(seed) & 32'h1) != 0;
    end
  end

  // Sink, random stalls only while a test asks for them
  always @(posedge clk) begin
    if (stall_enable) begin
      out_ready <= stall_draw;
    end else begin
      out_ready <= 1'b1;
    end
  end

  // Widening by bit replication equals c*4 + c/64
  function automatic pixel_out_t reference_beat(input pixel_in_t p);
    int         r;
    int         g;
    int         b;
    pixel_out_t beat;
    r = p.data[23:16];
    g = p.data[15:8];
    b = p.data[7:0];
    beat.rgb   = {10'(r * 4 + r / 64), 10'(g * 4 + g / 64), 10'(b * 4 + b / 64)};
    beat.luma  = 10'((r * default_r_weight + g * default_g_weight
                      + b * default_b_weight) / 64);
    beat.sop   = p.sop;
    beat.eop   = p.eop;
    beat.empty = p.empty;
    return beat;
  endfunction

  function automatic pixel_in_t framed_pixel(input rgb888_t data, input int index,
                                             input int length, input empty_t empty);
    pixel_in_t p;
    p.data  = data;
    p.sop   = (index == 0);
    p.eop   = (index == length - 1);
    p.empty = p.eop ? empty : 2'd0;
    return p;
  endfunction

  function automatic rgb888_t random_rgb();
    return rgb888_t'($random(seed));
  endfunction

  task automatic check_value(input string what, input logic [47:0] expected,
                             input logic [47:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  // Input side records expected beats, output side compares them
  always @(posedge clk) begin : monitor
    expect_t entry;
    if (reset) begin
      hold_pending = 1'b0;
    end else begin
      if (in_valid && in_ready) begin
        entry.beat  = reference_beat(in_pixel);
        entry.cycle = cycle;
        expect_q.push_back(entry);
        accepted++;
      end
      if (hold_pending) begin
        if (!out_valid) begin
          errors++;
          $display("%s: out_valid dropped while the sink was stalled", test_name);
        end else begin
          check_value("held beat", held_beat, out_pixel);
        end
      end
      if (out_valid && out_ready) begin
        received++;
        out_cycles.push_back(cycle);
        if (expect_q.size() == 0) begin
          errors++;
          $display("%s: extra output beat with no pixel pending", test_name);
        end else begin
          entry = expect_q.pop_front();
          check_value("rgb", entry.beat.rgb, out_pixel.rgb);
          check_value("luma", entry.beat.luma, out_pixel.luma);
          check_value("markers", {entry.beat.sop, entry.beat.eop, entry.beat.empty},
                      {out_pixel.sop, out_pixel.eop, out_pixel.empty});
          last_latency = cycle - int'(entry.cycle);
        end
      end
      hold_pending = out_valid && !out_ready;
      held_beat    = out_pixel;
    end
  end

  task automatic send_pixel(input pixel_in_t p);
    in_pixel <= p;
    in_valid <= 1'b1;
    @(posedge clk);
    while (!in_ready) @(posedge clk);
  endtask

  task automatic pause_input(input int cycles);
    in_valid <= 1'b0;
    repeat (cycles) @(posedge clk);
  endtask

  task automatic wait_drain();
    while (expect_q.size() != 0) @(posedge clk);
    // A few idle cycles to catch a duplicated beat
    repeat (6) @(posedge clk);
    if (received != accepted) begin
      errors++;
      $display("%s: %0d beats accepted but %0d received", test_name, accepted, received);
    end
  endtask

  task automatic reset_state();
    test_name = "reset_state";
    repeat (16) begin
      @(negedge clk);
      check_value("in_ready in reset", 48'd0, 48'(in_ready));
      check_value("out_valid in reset", 48'd0, 48'(out_valid));
    end
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("in_ready at release", 48'd0, 48'(in_ready));
    check_value("out_valid at release", 48'd0, 48'(out_valid));
    @(posedge clk);
    @(negedge clk);
    check_value("in_ready after release", 48'd1, 48'(in_ready));
    check_value("out_valid after release", 48'd0, 48'(out_valid));
    @(posedge clk);
  endtask

  task automatic single_pixel();
    rgb888_t colours[4];
    colours = '{24'h000000, 24'hffffff, 24'hff0000, 24'h808080};
    test_name = "single_pixel";
    foreach (colours[i]) begin
      send_pixel(framed_pixel(colours[i], 0, 1, 2'd0));
      pause_input(1);
      wait_drain();
      check_value("latency", 48'(pipe_latency), 48'(last_latency));
    end
  endtask

  task automatic packet_stream();
    int gaps;
    gaps = 0;
    test_name = "packet_stream";
    out_cycles.delete();
    for (int i = 0; i < 32; i++) begin
      send_pixel(framed_pixel(random_rgb(), i, 32, 2'd2));
    end
    pause_input(1);
    wait_drain();
    check_value("beats out", 48'd32, 48'(out_cycles.size()));
    for (int i = 1; i < out_cycles.size(); i++) begin
      if (out_cycles[i] != out_cycles[i - 1] + 1) begin
        gaps++;
      end
    end
    if (gaps != 0) begin
      errors++;
      $display("%s: output had %0d idle gaps inside the packet", test_name, gaps);
    end
  endtask

  task automatic back_pressure();
    test_name = "back_pressure";
    stall_enable <= 1'b1;
    for (int i = 0; i < 200; i++) begin
      send_pixel(framed_pixel(random_rgb(), i, 200, empty_t'($random(seed))));
    end
    pause_input(1);
    wait_drain();
    stall_enable <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic random_colours();
    int gap;
    test_name = "random_colours";
    for (int i = 0; i < 500; i++) begin
      send_pixel(framed_pixel(random_rgb(), i % 25, 25, empty_t'($random(seed))));
      gap = $random(seed) & 32'h3;
      if (gap != 0) begin
        pause_input(gap);
      end
    end
    pause_input(1);
    wait_drain();
  endtask

  initial begin
    seed         = 58097;
    reset        = 1'b1;
    in_pixel     = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b1;
    stall_enable = 1'b0;

    reset_state();
    single_pixel();
    packet_stream();
    back_pressure();
    random_colours();

    if (expect_q.size() != 0) begin
      errors++;
      $display("%0d expected beats never left the DUT", expect_q.size());
    end
    $display("errors: %0d, beats accepted: %0d, beats received: %0d",
             errors, accepted, received);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/video_resample_top.sv
// Video resample subsystem top
module video_resample_top #(
  parameter int r_weight = video_pkg::default_r_weight,
  parameter int g_weight = video_pkg::default_g_weight,
  parameter int b_weight = video_pkg::default_b_weight
) (
  input  logic                  clk,
  input  logic                  reset,
  input  video_pkg::pixel_in_t  in_pixel,
  input  logic                  in_valid,
  output logic                  in_ready,
  output video_pkg::pixel_out_t out_pixel,
  output logic                  out_valid,
  input  logic                  out_ready
);
  import video_pkg::*;

  // Fork to branches
  pixel_in_t rs_pixel;
  logic      rs_valid;
  logic      rs_ready;
  rgb888_t   lu_data;
  logic      lu_valid;
  logic      lu_ready;

  // Branches to merge
  rgb_beat_t rgb_beat;
  logic      rgb_valid;
  luma_t     luma;
  logic      luma_valid;
  logic      branch_ready;

  pixel_ingress pixel_ingress_i (
    .clk      (clk),
    .reset    (reset),
    .in_pixel (in_pixel),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .rs_pixel (rs_pixel),
    .rs_valid (rs_valid),
    .rs_ready (rs_ready),
    .lu_data  (lu_data),
    .lu_valid (lu_valid),
    .lu_ready (lu_ready)
  );

  rgb_resampler rgb_resampler_i (
    .clk       (clk),
    .reset     (reset),
    .in_pixel  (rs_pixel),
    .in_valid  (rs_valid),
    .in_ready  (rs_ready),
    .out_beat  (rgb_beat),
    .out_valid (rgb_valid),
    .out_ready (branch_ready)
  );

  luma_calc #(
    .r_weight (r_weight),
    .g_weight (g_weight),
    .b_weight (b_weight)
  ) luma_calc_i (
    .clk       (clk),
    .reset     (reset),
    .in_data   (lu_data),
    .in_valid  (lu_valid),
    .in_ready  (lu_ready),
    .luma      (luma),
    .out_valid (luma_valid),
    .out_ready (branch_ready)
  );

  pixel_merge pixel_merge_i (
    .clk          (clk),
    .reset        (reset),
    .rgb_beat     (rgb_beat),
    .rgb_valid    (rgb_valid),
    .luma         (luma),
    .luma_valid   (luma_valid),
    .branch_ready (branch_ready),
    .out_pixel    (out_pixel),
    .out_valid    (out_valid),
    .out_ready    (out_ready)
  );

endmodule

//--- hdl/pixel_merge.sv
// Branch merge output stage
module pixel_merge (
  input  logic                  clk,
  input  logic                  reset,
  input  video_pkg::rgb_beat_t  rgb_beat,
  input  logic                  rgb_valid,
  input  video_pkg::luma_t      luma,
  input  logic                  luma_valid,
  output logic                  branch_ready,
  output video_pkg::pixel_out_t out_pixel,
  output logic                  out_valid,
  input  logic                  out_ready
);
  import video_pkg::*;

  logic both_valid;
  logic out_fire;
  // Set between an output sop and its eop
  logic packet_open;

  assign both_valid = rgb_valid && luma_valid;
  assign out_fire   = out_valid && out_ready;

  // One ready for both branches keeps them in step
  assign branch_ready = !out_valid || out_ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_pixel <= '0;
      out_valid <= 1'b0;
    end else if (branch_ready) begin
      out_valid <= both_valid;
      if (both_valid) begin
        out_pixel.rgb   <= rgb_beat.data;
        out_pixel.luma  <= luma;
        out_pixel.sop   <= rgb_beat.sop;
        out_pixel.eop   <= rgb_beat.eop;
        out_pixel.empty <= rgb_beat.empty;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      packet_open <= 1'b0;
    end else if (out_fire) begin
      packet_open <= !out_pixel.eop;
    end
  end

  // Both branches were fed the same pixel on the same edge
  assert property (@(posedge clk) disable iff (reset)
    rgb_valid == luma_valid
  ) else $error("branch valids out of step");

  // Hold under back-pressure
  assert property (@(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_pixel))
  ) else $error("merge output changed under back-pressure");

  // A new packet only starts after the previous one has ended
  assert property (@(posedge clk) disable iff (reset)
    (out_fire && out_pixel.sop) |-> !packet_open
  ) else $error("sop while a packet is still open");

endmodule

//--- hdl/luma_calc.sv
// Weighted luma calculator
module luma_calc #(
  parameter int r_weight = 77,
  parameter int g_weight = 150,
  parameter int b_weight = 29
) (
  input  logic               clk,
  input  logic               reset,
  input  video_pkg::rgb888_t in_data,
  input  logic               in_valid,
  output logic               in_ready,
  output video_pkg::luma_t   luma,
  output logic               out_valid,
  input  logic               out_ready
);
  import video_pkg::*;

  // 8-bit channel times a weight of up to 256, three terms
  logic [17:0] weighted;
  luma_t       luma_next;

  initial begin
    assert (r_weight + g_weight + b_weight == luma_weight_sum)
      else $error("luma weights must sum to %0d", luma_weight_sum);
  end

  assign weighted = 18'(in_data[23:16]) * 18'(r_weight)
                  + 18'(in_data[15:8])  * 18'(g_weight)
                  + 18'(in_data[7:0])   * 18'(b_weight);

  // Divide by 64, white lands on 1020
  assign luma_next = luma_t'(weighted >> 6);

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      luma      <= '0;
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
      luma      <= luma_next;
    end
  end

  // Hold under back-pressure
  assert property (@(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(luma))
  ) else $error("luma output changed under back-pressure");

endmodule

//--- hdl/rgb_resampler.sv
// RGB888 to RGB101010 resampler
module rgb_resampler (
  input  logic                 clk,
  input  logic                 reset,
  input  video_pkg::pixel_in_t in_pixel,
  input  logic                 in_valid,
  output logic                 in_ready,
  output video_pkg::rgb_beat_t out_beat,
  output logic                 out_valid,
  input  logic                 out_ready
);
  import video_pkg::*;

  rgb10_t wide_data;

  // Append the two top bits so full scale maps to full scale
  function automatic logic [9:0] widen(input logic [7:0] chan);
    return {chan, chan[7:6]};
  endfunction

  assign wide_data = {widen(in_pixel.data[23:16]),
                      widen(in_pixel.data[15:8]),
                      widen(in_pixel.data[7:0])};

  // Free when empty or when the sink takes the current beat
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_beat  <= '0;
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid      <= in_valid;
      out_beat.data  <= wide_data;
      out_beat.sop   <= in_pixel.sop;
      out_beat.eop   <= in_pixel.eop;
      out_beat.empty <= in_pixel.empty;
    end
  end

  // Hold under back-pressure
  assert property (@(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
  ) else $error("resampler output changed under back-pressure");

  assert property (@(posedge clk) disable iff (reset)
    out_valid |-> !$isunknown(out_beat)
  ) else $error("resampler output unknown while valid");

endmodule

//--- hdl/pixel_ingress.sv
// Pixel ingress skid buffer and fork
module pixel_ingress (
  input  logic                 clk,
  input  logic                 reset,
  input  video_pkg::pixel_in_t in_pixel,
  input  logic                 in_valid,
  output logic                 in_ready,
  output video_pkg::pixel_in_t rs_pixel,
  output logic                 rs_valid,
  input  logic                 rs_ready,
  output video_pkg::rgb888_t   lu_data,
  output logic                 lu_valid,
  input  logic                 lu_ready
);
  import video_pkg::*;

  pixel_in_t main_pixel;
  logic      main_valid;
  pixel_in_t skid_pixel;
  logic      skid_valid;
  logic      accept;
  logic      pop;
  logic      main_load;

  assign accept = in_valid && in_ready;

  // Pixel leaves only when both branches take it on the same edge
  assign pop = main_valid && rs_ready && lu_ready;

  // Main register is free when empty or draining
  assign main_load = pop || !main_valid;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      main_pixel <= '0;
      main_valid <= 1'b0;
      skid_pixel <= '0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else begin
      if (main_load) begin
        if (skid_valid) begin
          // Skid beat goes first to keep order
          main_pixel <= skid_pixel;
          main_valid <= 1'b1;
          skid_valid <= 1'b0;
        end else begin
          main_valid <= accept;
          if (accept) begin
            main_pixel <= in_pixel;
          end
        end
        in_ready <= 1'b1;
      end else if (accept) begin
        // Main is stalled, park the beat in flight
        skid_pixel <= in_pixel;
        skid_valid <= 1'b1;
        in_ready   <= 1'b0;
      end
    end
  end

  // Fork, each valid is gated by the other branch's ready
  assign rs_pixel = main_pixel;
  assign rs_valid = main_valid && lu_ready;
  assign lu_data  = main_pixel.data;
  assign lu_valid = main_valid && rs_ready;

  // Branches run in lockstep so they see the same valid
  assert property (@(posedge clk) disable iff (reset)
    rs_valid == lu_valid
  ) else $error("fork valids differ");

  // Held pixel does not move while a branch stalls
  assert property (@(posedge clk) disable iff (reset)
    (main_valid && !pop) |=> (main_valid && $stable(main_pixel))
  ) else $error("ingress pixel changed while stalled");

endmodule

//--- hdl/video_pkg.sv
// Video pixel stream types
package video_pkg;

  // Channel and value widths
  typedef logic [23:0] rgb888_t;
  typedef logic [29:0] rgb10_t;
  typedef logic [9:0]  luma_t;
  typedef logic [1:0]  empty_t;

  // Input beat, RGB888 with packet markers
  typedef struct packed {
    rgb888_t data;
    logic    sop;
    logic    eop;
    empty_t  empty;
  } pixel_in_t;

  // Resampler result, RGB101010 with packet markers
  typedef struct packed {
    rgb10_t data;
    logic   sop;
    logic   eop;
    empty_t empty;
  } rgb_beat_t;

  // Merged output beat
  typedef struct packed {
    rgb10_t rgb;
    luma_t  luma;
    logic   sop;
    logic   eop;
    empty_t empty;
  } pixel_out_t;

  // Default luma weights, they sum to 256
  localparam int default_r_weight = 77;
  localparam int default_g_weight = 150;
  localparam int default_b_weight = 29;

  // Weight sum the luma scaling is built around
  localparam int luma_weight_sum = 256;

endpackage
